/* Makefile */
# Verilator build and run for the fosphor testbench

VERILATOR ?= verilator
TOP       ?= fosphor_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf $(OBJ_DIR)

/* common/fosphor_pkg.sv */
/*
  Shared definitions for the fosphor waterfall core and its testbench.
  Holds register addresses, stream and configuration structs and the
  waterfall divider table. Import it wherever these names are needed.
*/

`default_nettype none

package fosphor_pkg;

  // --------------------------------------------------------------------------
  // Widths
  // --------------------------------------------------------------------------

  // One FFT bin magnitude
  localparam int SAMPLE_W = 16;

  // Sum of up to 257 full-scale samples still fits
  localparam int ACC_W = 25;

  // Register port
  localparam int REG_ADDR_W = 8;
  localparam int REG_DATA_W = 32;

  // --------------------------------------------------------------------------
  // Register map
  // --------------------------------------------------------------------------

  // Bit 1 enables the waterfall, bit 0 is unused and reads 0
  localparam logic [REG_ADDR_W-1:0] REG_ENABLE   = 8'h00;
  // Write bit 1 to restart the group, reads 0
  localparam logic [REG_ADDR_W-1:0] REG_CLEAR    = 8'h04;
  localparam logic [REG_ADDR_W-1:0] REG_OFFSET   = 8'h08;
  localparam logic [REG_ADDR_W-1:0] REG_SCALE    = 8'h0C;
  // Bit 7 mode, bits 1:0 divider
  localparam logic [REG_ADDR_W-1:0] REG_WF_CTRL  = 8'h10;
  localparam logic [REG_ADDR_W-1:0] REG_WF_DECIM = 8'h14;

  // Average mode shift per divider setting: 1/1, 1/8, 1/64, 1/256
  localparam logic [3:0][3:0] WF_SHIFT = {4'd8, 4'd6, 4'd3, 4'd0};

  // --------------------------------------------------------------------------
  // Types
  // --------------------------------------------------------------------------

  typedef enum logic [0:0] {
    WF_MAX_HOLD = 1'b0,
    WF_AVERAGE  = 1'b1
  } wf_mode_e;

  // One stream beat, last marks the final bin of a packet
  typedef struct packed {
    logic [SAMPLE_W-1:0] data;
    logic                last;
  } bin_beat_t;

  // Scaler settings
  typedef struct packed {
    logic [15:0] offset;
    logic [15:0] gain;
  } scale_cfg_t;

  // Waterfall settings, a group is decim + 2 packets
  typedef struct packed {
    logic       en;
    wf_mode_e   mode;
    logic [1:0] div;
    logic [7:0] decim;
  } wf_cfg_t;

endpackage

`default_nettype wire

/* compile.f */
common/fosphor_pkg.sv
hdl/fosphor_regs.sv
hdl/mag_scaler.sv
waterfall/wf_accum.sv
hdl/fosphor_top.sv
testbench/fosphor_chk.sv
testbench/fosphor_tb.sv

/* hdl/fosphor_regs.sv */
/*
  Register bank of the fosphor core.
  Writes land on the edge where reg_wr is high, reads answer one cycle
  after reg_rd. Drives the scaler and waterfall settings and the clear pulse.
*/

`default_nettype none
`timescale 1ns/1ps

module fosphor_regs (
  input  logic                               ce_clk,
  input  logic                               reset,
  input  logic                               reg_wr,
  input  logic                               reg_rd,
  input  logic [fosphor_pkg::REG_ADDR_W-1:0] reg_addr,
  input  logic [fosphor_pkg::REG_DATA_W-1:0] reg_wdata,
  output logic [fosphor_pkg::REG_DATA_W-1:0] reg_rdata,
  output logic                               reg_rd_valid,
  output fosphor_pkg::scale_cfg_t            scale_cfg,
  output fosphor_pkg::wf_cfg_t               wf_cfg,
  output logic                               clear
);

  import fosphor_pkg::*;

  // Configuration fields at their own widths
  logic        en_wf;
  logic [15:0] offset;
  logic [15:0] gain;
  wf_mode_e    wf_mode;
  logic [1:0]  wf_div;
  logic [7:0]  wf_decim;

  // Read-back value for the current address
  logic [REG_DATA_W-1:0] rd_mux;

  // --------------------------------------------------------------------------
  // Write decode
  // --------------------------------------------------------------------------

  always_ff @(posedge ce_clk) begin
    if (reset) begin
      en_wf    <= 1'b0;
      offset   <= '0;
      gain     <= '0;
      wf_mode  <= WF_MAX_HOLD;
      wf_div   <= '0;
      wf_decim <= '0;
      clear    <= 1'b0;
    end else begin
      // Clear is a single-cycle strobe following the write
      clear <= reg_wr && (reg_addr == REG_CLEAR) && reg_wdata[1];
      if (reg_wr) begin
        case (reg_addr)
          REG_ENABLE:   en_wf    <= reg_wdata[1];
          REG_OFFSET:   offset   <= reg_wdata[15:0];
          REG_SCALE:    gain     <= reg_wdata[15:0];
          REG_WF_CTRL: begin
            wf_mode <= wf_mode_e'(reg_wdata[7]);
            wf_div  <= reg_wdata[1:0];
          end
          REG_WF_DECIM: wf_decim <= reg_wdata[7:0];
          default: ;
        endcase
      end
    end
  end

  // --------------------------------------------------------------------------
  // Read-back
  // --------------------------------------------------------------------------

  // Zero-extended fields, unmapped and REG_CLEAR read 0
  always_comb begin
    rd_mux = '0;
    case (reg_addr)
      REG_ENABLE:   rd_mux[1]    = en_wf;
      REG_OFFSET:   rd_mux[15:0] = offset;
      REG_SCALE:    rd_mux[15:0] = gain;
      REG_WF_CTRL: begin
        rd_mux[7]   = wf_mode;
        rd_mux[1:0] = wf_div;
      end
      REG_WF_DECIM: rd_mux[7:0]  = wf_decim;
      default: ;
    endcase
  end

  always_ff @(posedge ce_clk) begin
    if (reset) begin
      reg_rd_valid <= 1'b0;
    end else begin
      reg_rd_valid <= reg_rd;
    end
  end

  always_ff @(posedge ce_clk) begin
    if (reg_rd) begin
      reg_rdata <= rd_mux;
    end
  end

  // Settings out to the datapath
  assign scale_cfg = '{offset: offset, gain: gain};
  assign wf_cfg    = '{en: en_wf, mode: wf_mode, div: wf_div, decim: wf_decim};

endmodule

`default_nettype wire

/* hdl/fosphor_top.sv */
/*
  Top level of the single-clock fosphor waterfall core.
  Connects the register bank, the magnitude scaler and the waterfall
  accumulator. Feed FFT bin packets in, take decimated packets out.
*/

`default_nettype none
`timescale 1ns/1ps

module fosphor_top #(
  parameter int MAX_SPP = 128
) (
  input  logic                               ce_clk,
  input  logic                               reset,

  // Register port
  input  logic                               reg_wr,
  input  logic                               reg_rd,
  input  logic [fosphor_pkg::REG_ADDR_W-1:0] reg_addr,
  input  logic [fosphor_pkg::REG_DATA_W-1:0] reg_wdata,
  output logic [fosphor_pkg::REG_DATA_W-1:0] reg_rdata,
  output logic                               reg_rd_valid,

  // FFT bin input stream
  input  fosphor_pkg::bin_beat_t             in_beat,
  input  logic                               in_valid,
  output logic                               in_ready,

  // Waterfall output stream
  output fosphor_pkg::bin_beat_t             out_beat,
  output logic                               out_valid,
  input  logic                               out_ready
);

  import fosphor_pkg::*;

  // Configuration from the register bank
  scale_cfg_t scale_cfg;
  wf_cfg_t    wf_cfg;
  logic       clear;

  // Scaler to accumulator stream
  bin_beat_t  scaled_beat;
  logic       scaled_valid;
  logic       scaled_ready;

  fosphor_regs u_regs (
    .ce_clk       (ce_clk),
    .reset        (reset),
    .reg_wr       (reg_wr),
    .reg_rd       (reg_rd),
    .reg_addr     (reg_addr),
    .reg_wdata    (reg_wdata),
    .reg_rdata    (reg_rdata),
    .reg_rd_valid (reg_rd_valid),
    .scale_cfg    (scale_cfg),
    .wf_cfg       (wf_cfg),
    .clear        (clear)
  );

  mag_scaler u_scaler (
    .ce_clk       (ce_clk),
    .reset        (reset),
    .scale_cfg    (scale_cfg),
    .in_beat      (in_beat),
    .in_valid     (in_valid),
    .in_ready     (in_ready),
    .scaled_beat  (scaled_beat),
    .scaled_valid (scaled_valid),
    .scaled_ready (scaled_ready)
  );

  wf_accum #(
    .MAX_SPP (MAX_SPP)
  ) u_wf_accum (
    .ce_clk       (ce_clk),
    .reset        (reset),
    .wf_cfg       (wf_cfg),
    .clear        (clear),
    .scaled_beat  (scaled_beat),
    .scaled_valid (scaled_valid),
    .scaled_ready (scaled_ready),
    .out_beat     (out_beat),
    .out_valid    (out_valid),
    .out_ready    (out_ready)
  );

endmodule

`default_nettype wire

/* hdl/mag_scaler.sv */
/*
  Magnitude scaler, one valid/ready register stage.
  Each bin sample has the offset removed with a floor at zero, is
  multiplied by the gain in 8.8 fixed point and saturated to 16 bits.
*/

`default_nettype none
`timescale 1ns/1ps

module mag_scaler (
  input  logic                    ce_clk,
  input  logic                    reset,
  input  fosphor_pkg::scale_cfg_t scale_cfg,
  input  fosphor_pkg::bin_beat_t  in_beat,
  input  logic                    in_valid,
  output logic                    in_ready,
  output fosphor_pkg::bin_beat_t  scaled_beat,
  output logic                    scaled_valid,
  input  logic                    scaled_ready
);

  import fosphor_pkg::*;

  logic [SAMPLE_W-1:0]   diff;
  logic [2*SAMPLE_W-1:0] product;
  logic [SAMPLE_W-1:0]   result;

  // Offset subtraction, negative results floor at 0
  assign diff = (in_beat.data > scale_cfg.offset) ? (in_beat.data - scale_cfg.offset) : '0;

  // Gain has 8 fractional bits
  assign product = diff * scale_cfg.gain;

  // Anything above bit 23 overflows the 16-bit output
  assign result = (|product[2*SAMPLE_W-1:SAMPLE_W+8]) ? '1 : product[SAMPLE_W+7:8];

  // Stage can take a beat when empty or draining
  assign in_ready = ~scaled_valid | scaled_ready;

  always_ff @(posedge ce_clk) begin
    if (reset) begin
      scaled_valid <= 1'b0;
    end else if (in_ready) begin
      scaled_valid <= in_valid;
    end
  end

  // Payload, last passes straight through
  always_ff @(posedge ce_clk) begin
    if (in_valid && in_ready) begin
      scaled_beat.data <= result;
      scaled_beat.last <= in_beat.last;
    end
  end

endmodule

`default_nettype wire

/* testbench/fosphor_chk.sv */
/*
  Concurrent checks on the waterfall output stream.
  Bound into every wf_accum instance, counts its own assertion failures.
*/

`default_nettype none
`timescale 1ns/1ps

module fosphor_chk #(
  parameter int MAX_SPP = 128,
  parameter int IDX_W   = 7
) (
  input logic                   ce_clk,
  input logic                   reset,
  input fosphor_pkg::bin_beat_t out_beat,
  input logic                   out_valid,
  input logic                   out_ready,
  input logic [IDX_W-1:0]       bin_idx
);

  int fail_cnt = 0;

  // A stalled beat holds still until the sink takes it
  hold_stable: assert property (@(posedge ce_clk) disable iff (reset)
    (out_valid && !out_ready) |=> $stable(out_beat))
    else begin
      fail_cnt++;
      $error("out_beat changed while stalled");
    end

  // Nothing valid straight out of reset
  reset_idle: assert property (@(posedge ce_clk) reset |=> !out_valid)
    else begin
      fail_cnt++;
      $error("out_valid high after reset");
    end

  // Bin index stays inside the group memory
  idx_range: assert property (@(posedge ce_clk) disable iff (reset)
    int'(bin_idx) < MAX_SPP)
    else begin
      fail_cnt++;
      $error("bin index out of range");
    end

endmodule

bind wf_accum fosphor_chk #(
  .MAX_SPP (MAX_SPP),
  .IDX_W   (IDX_W)
) u_chk (
  .ce_clk    (ce_clk),
  .reset     (reset),
  .out_beat  (out_beat),
  .out_valid (out_valid),
  .out_ready (out_ready),
  .bin_idx   (bin_idx)
);

`default_nettype wire

/* testbench/fosphor_stim.txt */
// en mode div decim offset gain packets length expected_out_packets (all hex)
// A line starting with ff ends the list
// Packet count per decimation, max hold at unity gain
1 0 0 00 0000 0100 07 10 03
1 0 0 01 0000 0100 0a 08 03
1 0 0 02 0000 0100 09 0c 02
1 0 0 03 0000 0100 0b 05 02
1 0 0 04 0000 0100 0c 07 02
// Max hold with offset floor and gain saturation
1 0 0 02 4000 0180 08 20 02
1 0 0 00 c000 0400 06 40 03
// Average mode for each divider
1 1 0 00 0000 0040 06 10 03
1 1 1 05 0000 0100 0e 18 02
1 1 2 3e 0000 0100 40 04 01
1 1 3 ff 0000 0100 101 02 01
1 1 0 01 1000 0200 06 10 02
// Waterfall disabled
0 0 0 00 0000 0100 06 10 00
// Full length and single bin packets
1 0 0 00 0000 0100 04 80 02
1 1 1 00 0000 0100 05 01 02
ff ff ff ff ff ff ff ff ff

/* testbench/fosphor_tb.sv */
/*
  Testbench for the fosphor waterfall core.
  Reads one test per line from the stim file, drives random bin samples,
  and checks every output beat against a model of the scaler and waterfall.
*/

`default_nettype none
`timescale 1ns/1ps

module fosphor_tb;

  import fosphor_pkg::*;

  // Deeper than the longest test packet, with index codes left above the memory
  localparam int MAX_SPP   = 160;
  localparam int N_FIELDS  = 9;
  localparam int MAX_TESTS = 32;

  logic                  ce_clk;
  logic                  reset;
  logic                  reg_wr;
  logic                  reg_rd;
  logic [REG_ADDR_W-1:0] reg_addr;
  logic [REG_DATA_W-1:0] reg_wdata;
  logic [REG_DATA_W-1:0] reg_rdata;
  logic                  reg_rd_valid;
  bin_beat_t             in_beat;
  logic                  in_valid;
  logic                  in_ready;
  bin_beat_t             out_beat;
  logic                  out_valid;
  logic                  out_ready;

  logic [31:0] stim_mem [MAX_TESTS*N_FIELDS];
  logic [15:0] samples [$];
  bin_beat_t   exp_q [$];
  integer      seed;
  int          errors;
  int          out_pkts;
  int          tests_run;
  int          tests_failed;
  int          limit_cycles;
  logic        stall_en;

  // Average mode shift for wf_div 0..3
  int shifts [4] = '{0, 3, 6, 8};

  fosphor_top #(.MAX_SPP(MAX_SPP)) UUT (
    .ce_clk(ce_clk), .reset(reset), .reg_wr(reg_wr), .reg_rd(reg_rd),
    .reg_addr(reg_addr), .reg_wdata(reg_wdata), .reg_rdata(reg_rdata),
    .reg_rd_valid(reg_rd_valid), .in_beat(in_beat), .in_valid(in_valid),
    .in_ready(in_ready), .out_beat(out_beat), .out_valid(out_valid),
    .out_ready(out_ready)
  );

  initial ce_clk = 1'b0;
  always #10 ce_clk = ~ce_clk;

  // Random sink stalls while a test asks for them
  always @(negedge ce_clk) begin
    if (stall_en) out_ready = (($random(seed) & 3) != 0);
    else out_ready = 1'b1;
  end

  // --------------------------------------------------------------------------
  // Output monitor
  // --------------------------------------------------------------------------

  always @(posedge ce_clk) begin
    bin_beat_t exp;
    if (!reset && out_valid && out_ready) begin
      assert (exp_q.size() > 0) else begin
        errors++;
        $display("output beat at %0t when none was expected", $time);
      end
      if (exp_q.size() > 0) begin
        exp = exp_q.pop_front();
        assert (out_beat.data == exp.data) else begin
          errors++;
          $display("error at %0t: out_beat.data expected %h got %h", $time, exp.data,
                   out_beat.data);
        end
        assert (out_beat.last == exp.last) else begin
          errors++;
          $display("error at %0t: out_beat.last expected %b got %b", $time, exp.last,
                   out_beat.last);
        end
        if (out_beat.last) out_pkts++;
      end
    end
  end

  // --------------------------------------------------------------------------
  // Register access and reference model
  // --------------------------------------------------------------------------

  task automatic reg_write(input logic [REG_ADDR_W-1:0] addr, input logic [31:0] data);
    @(negedge ce_clk);
    reg_wr    = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    @(negedge ce_clk);
    reg_wr    = 1'b0;
  endtask

  // Result is due one cycle after the read strobe
  task automatic reg_expect(input logic [REG_ADDR_W-1:0] addr, input logic [31:0] exp);
    @(negedge ce_clk);
    reg_rd   = 1'b1;
    reg_addr = addr;
    @(negedge ce_clk);
    reg_rd   = 1'b0;
    assert (reg_rd_valid) else begin
      errors++;
      $display("read of register %h at %0t gave no reg_rd_valid", addr, $time);
    end
    assert (reg_rdata == exp) else begin
      errors++;
      $display("error at %0t: reg_rdata of %h expected %h got %h", $time, addr, exp,
               reg_rdata);
    end
  endtask

  // Offset with floor, gain in 1/256 steps, clip to 16 bits
  function automatic int scaled_value(input int sample, input int offset, input int gain);
    longint prod;
    prod = (sample > offset) ? longint'(sample - offset) * gain : 64'sd0;
    prod = prod / 256;
    return (prod > 65535) ? 65535 : int'(prod);
  endfunction

  task automatic send_packets(input int npkt, input int len);
    for (int i = 0; i < npkt * len; i++) begin
      @(negedge ce_clk);
      in_valid     = 1'b1;
      in_beat.data = samples[i];
      in_beat.last = ((i % len) == len - 1);
      @(posedge ce_clk);
      while (!in_ready) @(posedge ce_clk);
    end
    @(negedge ce_clk);
    in_valid = 1'b0;
  endtask

  task automatic register_test();
    int err_before;
    err_before = errors;
    reg_expect(REG_ENABLE, 32'h0);
    reg_expect(REG_CLEAR, 32'h0);
    reg_expect(REG_OFFSET, 32'h0);
    reg_expect(REG_SCALE, 32'h0);
    reg_expect(REG_WF_CTRL, 32'h0);
    reg_expect(REG_WF_DECIM, 32'h0);
    // Every field keeps only its own width
    reg_write(REG_ENABLE, 32'hFFFF_FFFF);
    reg_write(REG_CLEAR, 32'hFFFF_FFFF);
    reg_write(REG_OFFSET, 32'hFFFF_ABCD);
    reg_write(REG_SCALE, 32'h1234_5678);
    reg_write(REG_WF_CTRL, 32'hFFFF_FFFF);
    reg_write(REG_WF_DECIM, 32'hFFFF_FF5A);
    reg_write(8'h18, 32'hFFFF_FFFF);
    reg_expect(REG_ENABLE, 32'h2);
    reg_expect(REG_CLEAR, 32'h0);
    reg_expect(REG_OFFSET, 32'h0000_ABCD);
    reg_expect(REG_SCALE, 32'h0000_5678);
    reg_expect(REG_WF_CTRL, 32'h0000_0083);
    reg_expect(REG_WF_DECIM, 32'h0000_005A);
    reg_expect(8'h18, 32'h0);
    reg_write(REG_ENABLE, 32'h0);
    tests_run++;
    if (errors != err_before) tests_failed++;
    $display("test regs %s", (errors == err_before) ? "ok" : "FAILED");
  endtask

  // --------------------------------------------------------------------------
  // One line of the stim file
  // --------------------------------------------------------------------------

  task automatic run_test(input int t);
    int f [N_FIELDS];
    int grp;
    int acc;
    int v;
    int err_before;
    bin_beat_t beat;
    for (int k = 0; k < N_FIELDS; k++) f[k] = int'(stim_mem[t*N_FIELDS + k]);
    err_before = errors;
    grp = f[3] + 2;
    samples.delete();
    for (int i = 0; i < f[6] * f[7]; i++) samples.push_back(16'($random(seed)));
    reg_write(REG_ENABLE, 32'(f[0] << 1));
    reg_write(REG_WF_CTRL, 32'((f[1] << 7) | f[2]));
    reg_write(REG_WF_DECIM, 32'(f[3]));
    reg_write(REG_OFFSET, 32'(f[4]));
    reg_write(REG_SCALE, 32'(f[5]));
    reg_write(REG_CLEAR, 32'h2);
    // A partial group that the next clear must discard
    send_packets(1, f[7]);
    repeat (2) @(negedge ce_clk);
    reg_write(REG_CLEAR, 32'h2);
    repeat (2) @(negedge ce_clk);
    // Expected beats group by group and bin by bin
    if (f[0] != 0) begin
      for (int g = 0; g < f[6] / grp; g++) begin
        for (int b = 0; b < f[7]; b++) begin
          acc = 0;
          for (int k = 0; k < grp; k++) begin
            v = scaled_value(int'(samples[(g*grp + k)*f[7] + b]), f[4], f[5]);
            if (f[1] != 0) acc += v;
            else if (v > acc) acc = v;
          end
          if (f[1] != 0) acc = acc >> shifts[f[2]];
          if (acc > 65535) acc = 65535;
          beat.data = 16'(acc);
          beat.last = (b == f[7] - 1);
          exp_q.push_back(beat);
        end
      end
    end
    out_pkts = 0;
    stall_en = t[0];
    send_packets(f[6], f[7]);
    while (exp_q.size() != 0) @(posedge ce_clk);
    repeat (4) @(posedge ce_clk);
    stall_en = 1'b0;
    assert (out_pkts == f[8]) else begin
      errors++;
      $display("error at %0t: output packets expected %0d got %0d", $time, f[8], out_pkts);
    end
    tests_run++;
    if (errors != err_before) tests_failed++;
    $display("test %0d %s: en=%0d mode=%0d div=%0d decim=%0d packets=%0d len=%0d out=%0d",
             t, (errors == err_before) ? "ok" : "FAILED", f[0], f[1], f[2], f[3], f[6],
             f[7], out_pkts);
  endtask

  initial begin
    int t;
    reset     = 1'b1;
    reg_wr    = 1'b0;
    reg_rd    = 1'b0;
    reg_addr  = '0;
    reg_wdata = '0;
    in_beat   = '0;
    in_valid  = 1'b0;
    out_ready = 1'b1;
    stall_en  = 1'b0;
    seed      = 48;
    errors    = 0;
    $readmemh("testbench/fosphor_stim.txt", stim_mem);
    // Four cycles per beat covers stalls, plus register traffic per test
    limit_cycles = 2000;
    for (t = 0; t < MAX_TESTS && stim_mem[t*N_FIELDS] != 32'hFF; t++) begin
      limit_cycles += int'(stim_mem[t*N_FIELDS + 6] + 1) * int'(stim_mem[t*N_FIELDS + 7]) * 4;
      limit_cycles += 100;
    end
    fork
      begin
        repeat (limit_cycles) @(posedge ce_clk);
        $display("run stopped by the watchdog after %0d cycles", limit_cycles);
        $display("Simulation failed");
        $finish;
      end
    join_none
    repeat (3) @(posedge ce_clk);
    @(negedge ce_clk);
    reset = 1'b0;
    register_test();
    for (t = 0; t < MAX_TESTS && stim_mem[t*N_FIELDS] != 32'hFF; t++) run_test(t);
    errors += UUT.u_wf_accum.u_chk.fail_cnt;
    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* waterfall/wf_accum.sv */
/*
  Waterfall accumulator.
  Folds each group of decim + 2 packets into one packet of the same
  length, by per-bin maximum or by per-bin sum with a divider shift.
  The last packet of a group streams the result out, one beat per bin.
*/

`default_nettype none
`timescale 1ns/1ps

module wf_accum #(
  parameter int MAX_SPP = 128
) (
  input  logic                   ce_clk,
  input  logic                   reset,
  input  fosphor_pkg::wf_cfg_t   wf_cfg,
  input  logic                   clear,
  input  fosphor_pkg::bin_beat_t scaled_beat,
  input  logic                   scaled_valid,
  output logic                   scaled_ready,
  output fosphor_pkg::bin_beat_t out_beat,
  output logic                   out_valid,
  input  logic                   out_ready
);

  import fosphor_pkg::*;

  localparam int IDX_W = (MAX_SPP > 1) ? $clog2(MAX_SPP) : 1;
  // Counts up to 256 packets within a group
  localparam int CNT_W = 9;

  // Per-bin partial result of the current group
  logic [ACC_W-1:0]    bin_mem [MAX_SPP];

  logic [IDX_W-1:0]    bin_idx;
  logic [CNT_W-1:0]    pkt_cnt;
  logic [CNT_W-1:0]    last_pkt;

  logic                xfer;
  logic                take;
  logic                first_pkt;
  logic                final_pkt;

  logic [ACC_W-1:0]    sample_ext;
  logic [ACC_W-1:0]    stored;
  logic [ACC_W-1:0]    combined;
  logic [ACC_W-1:0]    shifted;
  logic [SAMPLE_W-1:0] out_data;

  // --------------------------------------------------------------------------
  // Handshake and group position
  // --------------------------------------------------------------------------

  // Only a stalled output blocks the input
  assign scaled_ready = ~(out_valid & ~out_ready);
  assign xfer         = scaled_valid & scaled_ready;

  // Beats are dropped when disabled or on a clear cycle
  assign take = xfer & wf_cfg.en & ~clear;

  assign last_pkt  = CNT_W'(wf_cfg.decim) + CNT_W'(1);
  assign first_pkt = (pkt_cnt == '0);
  assign final_pkt = (pkt_cnt >= last_pkt);

  // --------------------------------------------------------------------------
  // Combine datapath
  // --------------------------------------------------------------------------

  assign sample_ext = ACC_W'(scaled_beat.data);
  assign stored     = bin_mem[bin_idx];

  always_comb begin
    if (wf_cfg.mode == WF_MAX_HOLD) begin
      combined = (stored > sample_ext) ? stored : sample_ext;
      shifted  = combined;
    end else begin
      combined = stored + sample_ext;
      shifted  = combined >> WF_SHIFT[wf_cfg.div];
    end
  end

  // Clip to the output sample width
  assign out_data = (|shifted[ACC_W-1:SAMPLE_W]) ? '1 : shifted[SAMPLE_W-1:0];

  // First packet seeds the bins, middle packets fold in
  always_ff @(posedge ce_clk) begin
    if (take && !final_pkt) begin
      bin_mem[bin_idx] <= first_pkt ? sample_ext : combined;
    end
  end

  // --------------------------------------------------------------------------
  // Counters and output valid
  // --------------------------------------------------------------------------

  always_ff @(posedge ce_clk) begin
    if (reset) begin
      bin_idx   <= '0;
      pkt_cnt   <= '0;
      out_valid <= 1'b0;
    end else begin
      if (out_valid && out_ready) begin
        out_valid <= 1'b0;
      end
      if (clear || !wf_cfg.en) begin
        bin_idx <= '0;
        pkt_cnt <= '0;
      end else if (xfer) begin
        if (scaled_beat.last) begin
          bin_idx <= '0;
          pkt_cnt <= final_pkt ? '0 : pkt_cnt + 1'b1;
        end else if (bin_idx != IDX_W'(MAX_SPP - 1)) begin
          // Overlong packets keep folding into the top bin
          bin_idx <= bin_idx + 1'b1;
        end
        if (final_pkt) begin
          out_valid <= 1'b1;
        end
      end
    end
  end

  // Result beat of the final packet, last copied from the input
  always_ff @(posedge ce_clk) begin
    if (take && final_pkt) begin
      out_beat.data <= out_data;
      out_beat.last <= scaled_beat.last;
    end
  end

endmodule

`default_nettype wire
